// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_xm_regs
FILELIST  = files.f
RUNFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(RUNFLAGS)); echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: bus_pkg.sv
// bus synchronizer depth and clock rates

package bus_pkg;

    // flops per synchronizer on the asynchronous CPU bus inputs
    localparam int SYNC_STAGES = 2;

    localparam int PCLK_HZ = 50_000_000;    // default pixel clock

    // clocks per timer tick, one tick every 0.1 ms
    localparam int TIMER_DIV_DEFAULT = PCLK_HZ / 10_000;

endpackage

// File: bus_sync.sv
`default_nettype none
`timescale 1ns/1ps

module bus_sync (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           bus_cs_n_i,     // low for one byte access
    input  wire logic                           bus_rd_nwr_i,   // 0 write, 1 read
    input  wire logic [regs_pkg::REG_NUM_W-1:0] bus_reg_num_i,  // register number
    input  wire logic                           bus_bytesel_i,  // 0 even byte, 1 odd byte
    input  wire logic [regs_pkg::BYTE_W-1:0]    bus_data_i,     // write data from CPU
    output      logic                           write_strobe_o, // one clock per byte write
    output      logic                           read_strobe_o,  // one clock per byte read
    output      logic [regs_pkg::REG_NUM_W-1:0] reg_num_o,      // held until next access
    output      logic                           bytesel_o,
    output      logic [regs_pkg::BYTE_W-1:0]    bytedata_o
);

localparam int N = bus_pkg::SYNC_STAGES;

logic [N-1:0]                   cs_sync;        // index N-1 is the synchronized cs
logic [N-1:0]                   rd_nwr_sync;
logic [N-1:0]                   bytesel_sync;
logic [regs_pkg::REG_NUM_W-1:0] reg_num_sync [N];
logic [regs_pkg::BYTE_W-1:0]    data_sync    [N];
logic                           cs_prev;        // synchronized cs one clock ago
logic                           cs_fall;

assign cs_fall = cs_prev & ~cs_sync[N-1];      // start of an access

// cs idles high, so reset sets the chain high and no strobe fires after reset
always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_sync <= '1;
        cs_prev <= 1'b1;
    end else begin
        cs_sync[0] <= bus_cs_n_i;
        for (int i = 1; i < N; i++) begin
            cs_sync[i] <= cs_sync[i-1];
        end
        cs_prev <= cs_sync[N-1];
    end
end

always_ff @(posedge clk) begin
    rd_nwr_sync[0]  <= bus_rd_nwr_i;
    bytesel_sync[0] <= bus_bytesel_i;
    reg_num_sync[0] <= bus_reg_num_i;
    data_sync[0]    <= bus_data_i;
    for (int i = 1; i < N; i++) begin
        rd_nwr_sync[i]  <= rd_nwr_sync[i-1];
        bytesel_sync[i] <= bytesel_sync[i-1];
        reg_num_sync[i] <= reg_num_sync[i-1];
        data_sync[i]    <= data_sync[i-1];
    end
end

// strobe lands SYNC_STAGES+1 clock edges after cs goes low
always_ff @(posedge clk) begin
    if (reset_i) begin
        write_strobe_o <= 1'b0;
        read_strobe_o  <= 1'b0;
        reg_num_o      <= '0;
        bytesel_o      <= 1'b0;
    end else begin
        write_strobe_o <= cs_fall & ~rd_nwr_sync[N-1];
        read_strobe_o  <= cs_fall & rd_nwr_sync[N-1];
        if (cs_fall) begin
            reg_num_o <= reg_num_sync[N-1];    // also selects the readback byte
            bytesel_o <= bytesel_sync[N-1];
        end
    end
end

always_ff @(posedge clk) begin
    if (cs_fall) begin
        bytedata_o <= data_sync[N-1];
    end
end

endmodule

`default_nettype wire

// File: files.f
regs_pkg.sv
bus_pkg.sv
bus_sync.sv
vram_regs.sv
vram_access.sv
xm_regs_top.sv
xm_regs_asserts.sv
tb_xm_regs.sv

// File: regs_pkg.sv
// register map and word layout of the host register block

package regs_pkg;

    localparam int REG_NUM_W = 4;           // register number on the bus
    localparam int WORD_W    = 16;          // register and VRAM word
    localparam int BYTE_W    = 8;           // CPU bus byte

    // register numbers
    // numbers not listed here read back as zero and ignore writes
    localparam logic [REG_NUM_W-1:0] XM_RD_INCR = 4'h2;    // VRAM read increment
    localparam logic [REG_NUM_W-1:0] XM_RD_ADDR = 4'h3;    // VRAM read address
    localparam logic [REG_NUM_W-1:0] XM_WR_INCR = 4'h4;    // VRAM write increment
    localparam logic [REG_NUM_W-1:0] XM_WR_ADDR = 4'h5;    // VRAM write address
    localparam logic [REG_NUM_W-1:0] XM_DATA    = 4'h6;    // VRAM data port
    localparam logic [REG_NUM_W-1:0] XM_TIMER   = 4'h8;    // tenth ms tick counter

    // One register word has two views.
    // word is used for address arithmetic and VRAM data,
    // bytes for the even/odd bus byte accesses
    typedef union packed {
        logic [WORD_W-1:0] word;            // whole 16 bit value
        struct packed {
            logic [BYTE_W-1:0] hi;          // even byte, bytesel 0
            logic [BYTE_W-1:0] lo;          // odd byte, bytesel 1
        } bytes;
    } reg_word_u;

endpackage

// File: tb_xm_regs.sv
`timescale 1ns/1ps

module tb_xm_regs;

localparam int CLK_PERIOD = 20;
localparam int TIMER_DIV  = 20;
localparam int ROUNDS     = 4;          // passes of each random test
localparam int N_WORDS    = 8;          // DATA words per pass
localparam int NUM_OPS    = 2*10 + 2*2 + ROUNDS*12 + 10*4 + 2*ROUNDS*(10 + 2*N_WORDS);
localparam int LIMIT_CLKS = NUM_OPS*40 + 2*256 + 500;

logic                           clk = 1'b0;
logic                           reset;
logic                           bus_cs_n;
logic                           bus_rd_nwr;
logic [regs_pkg::REG_NUM_W-1:0] bus_reg_num;
logic                           bus_bytesel;
logic [regs_pkg::BYTE_W-1:0]    bus_wdata;
logic [regs_pkg::BYTE_W-1:0]    bus_rdata;
logic                           vram_sel;
logic                           vram_wr;
logic [regs_pkg::WORD_W-1:0]    vram_addr;
logic [regs_pkg::WORD_W-1:0]    vram_wdata;
logic                           vram_ack;
logic [regs_pkg::WORD_W-1:0]    vram_rdata;

regs_pkg::reg_word_u mem [256];         // VRAM model indexed by low address byte
regs_pkg::reg_word_u last_wr_addr;      // full address of the last VRAM write
regs_pkg::reg_word_u last_rd_addr;      // full address of the last VRAM read
logic [15:0]         lfsr = 16'h0002;
int                  ack_delay = 1;     // clocks from select to ack
int                  wait_left;
logic                serving = 1'b0;
int                  cycle = 0;
int                  sample_cycle;      // cycle of the last bus sample

always #(CLK_PERIOD/2) clk = ~clk;

always @(posedge clk) cycle <= cycle + 1;

xm_regs_top #(
    .TIMER_DIV (TIMER_DIV)
) uut (
    .clk           (clk),
    .reset_i       (reset),
    .bus_cs_n_i    (bus_cs_n),
    .bus_rd_nwr_i  (bus_rd_nwr),
    .bus_reg_num_i (bus_reg_num),
    .bus_bytesel_i (bus_bytesel),
    .bus_data_i    (bus_wdata),
    .bus_data_o    (bus_rdata),
    .vram_sel_o    (vram_sel),
    .vram_wr_o     (vram_wr),
    .vram_addr_o   (vram_addr),
    .vram_data_o   (vram_wdata),
    .vram_ack_i    (vram_ack),
    .vram_data_i   (vram_rdata)
);

// memory responder answering one select after ack_delay clocks
always @(negedge clk) begin
    if (reset || vram_ack) begin
        vram_ack = 1'b0;
        serving  = 1'b0;
    end else if (vram_sel) begin
        if (!serving) begin
            serving   = 1'b1;
            wait_left = ack_delay;
        end
        wait_left = wait_left - 1;
        if (wait_left == 0) begin
            if (vram_wr) begin
                mem[vram_addr[7:0]].word = vram_wdata;
                last_wr_addr.word        = vram_addr;
            end else begin
                vram_rdata        = mem[vram_addr[7:0]].word;
                last_rd_addr.word = vram_addr;
            end
            vram_ack = 1'b1;
            serving  = 1'b0;
        end
    end
end

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_word(input regs_pkg::reg_word_u got, input regs_pkg::reg_word_u exp,
                          input string what);
    if (got.word !== exp.word) begin
        abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                            $time, what, got.word, exp.word));
    end
endtask

task automatic check_byte(input logic [regs_pkg::BYTE_W-1:0] got,
                          input logic [regs_pkg::BYTE_W-1:0] exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

// 16 bit fibonacci LFSR with taps 16 14 13 11 stepped once per bit
function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        v    = {v[14:0], lfsr[0]};
    end
    return v;
endfunction

task automatic wait_vram_idle();
    int n;
    n = 0;
    while (vram_sel) begin
        @(negedge clk);
        n++;
        if (n > 16) abort_run("VRAM select stayed high, no acknowledge came back");
    end
endtask

// one byte access with cs low 6 clocks then high 6 clocks
task automatic bus_access(input logic rd, input logic [regs_pkg::REG_NUM_W-1:0] num,
                          input logic sel, input logic [regs_pkg::BYTE_W-1:0] wdata,
                          output logic [regs_pkg::BYTE_W-1:0] rdata);
    ack_delay   = 1 + int'(random_bits(2));
    bus_rd_nwr  = rd;
    bus_reg_num = num;
    bus_bytesel = sel;
    bus_wdata   = wdata;
    bus_cs_n    = 1'b0;
    repeat (6) @(negedge clk);
    rdata        = bus_rdata;               // strobe long past so the byte is stable
    sample_cycle = cycle;
    bus_cs_n     = 1'b1;
    repeat (6) @(negedge clk);
    wait_vram_idle();
endtask

task automatic write_reg(input logic [regs_pkg::REG_NUM_W-1:0] num,
                         input regs_pkg::reg_word_u w);
    logic [regs_pkg::BYTE_W-1:0] ignored;
    bus_access(1'b0, num, 1'b0, w.bytes.hi, ignored);   // even byte first
    bus_access(1'b0, num, 1'b1, w.bytes.lo, ignored);
endtask

task automatic read_reg(input logic [regs_pkg::REG_NUM_W-1:0] num,
                        output regs_pkg::reg_word_u w);
    logic [regs_pkg::BYTE_W-1:0] hi;
    logic [regs_pkg::BYTE_W-1:0] lo;
    bus_access(1'b1, num, 1'b0, 8'h00, hi);
    bus_access(1'b1, num, 1'b1, 8'h00, lo);
    w.bytes.hi = hi;
    w.bytes.lo = lo;
endtask

task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
endtask

task automatic check_reset_values();
    regs_pkg::reg_word_u got;
    regs_pkg::reg_word_u zero;
    zero.word = '0;
    read_reg(regs_pkg::XM_RD_INCR, got);
    check_word(got, zero, "RD_INCR after reset");
    read_reg(regs_pkg::XM_RD_ADDR, got);
    check_word(got, zero, "RD_ADDR after reset");
    read_reg(regs_pkg::XM_WR_INCR, got);
    check_word(got, zero, "WR_INCR after reset");
    read_reg(regs_pkg::XM_WR_ADDR, got);
    check_word(got, zero, "WR_ADDR after reset");
    read_reg(regs_pkg::XM_DATA, got);       // read latch still zero
    check_word(got, zero, "DATA after reset");
endtask

// two lo byte samples of the tick counter k clocks apart
task automatic timer_test(input int gap);
    logic [regs_pkg::BYTE_W-1:0] first;
    logic [regs_pkg::BYTE_W-1:0] second;
    logic [regs_pkg::BYTE_W-1:0] step;
    int                          c0;
    int                          k;
    bus_access(1'b1, regs_pkg::XM_TIMER, 1'b1, 8'h00, first);
    c0 = sample_cycle;
    repeat (gap) @(negedge clk);
    bus_access(1'b1, regs_pkg::XM_TIMER, 1'b1, 8'h00, second);
    k    = sample_cycle - c0;
    step = second - first;                  // wraps with the lo byte
    if (int'(step) != k / TIMER_DIV && int'(step) != k / TIMER_DIV + 1) begin
        abort_run($sformatf("Fail at %0t ns: TIMER moved by %0d in %0d clocks",
                            $time, step, k));
    end
endtask

task automatic roundtrip_reg(input logic [regs_pkg::REG_NUM_W-1:0] num, input string what);
    regs_pkg::reg_word_u         w;
    logic [regs_pkg::BYTE_W-1:0] b;
    w.word = random_bits(16);
    write_reg(num, w);
    bus_access(1'b1, num, 1'b0, 8'h00, b);
    check_byte(b, w.bytes.hi, {what, " even byte"});
    bus_access(1'b1, num, 1'b1, 8'h00, b);
    check_byte(b, w.bytes.lo, {what, " odd byte"});
endtask

task automatic check_unused_regs();
    regs_pkg::reg_word_u         w;
    logic [regs_pkg::BYTE_W-1:0] b;
    for (int n = 0; n < 16; n++) begin
        if (4'(n) inside {regs_pkg::XM_RD_INCR, regs_pkg::XM_RD_ADDR, regs_pkg::XM_WR_INCR,
                          regs_pkg::XM_WR_ADDR, regs_pkg::XM_DATA, regs_pkg::XM_TIMER}) begin
            continue;
        end
        w.word = random_bits(16);
        write_reg(4'(n), w);                // must be ignored
        bus_access(1'b1, 4'(n), 1'b0, 8'h00, b);
        check_byte(b, 8'h00, $sformatf("register %0d even byte", n));
        bus_access(1'b1, 4'(n), 1'b1, 8'h00, b);
        check_byte(b, 8'h00, $sformatf("register %0d odd byte", n));
    end
endtask

task automatic data_write_run();
    regs_pkg::reg_word_u incr;
    regs_pkg::reg_word_u exp_addr;
    regs_pkg::reg_word_u data;
    regs_pkg::reg_word_u got;
    incr.word     = random_bits(16);
    exp_addr.word = random_bits(16);
    write_reg(regs_pkg::XM_WR_INCR, incr);
    write_reg(regs_pkg::XM_WR_ADDR, exp_addr);
    for (int i = 0; i < N_WORDS; i++) begin
        data.word         = random_bits(16);
        last_wr_addr.word = ~exp_addr.word;         // stale value cannot match
        write_reg(regs_pkg::XM_DATA, data);
        check_word(last_wr_addr, exp_addr, "VRAM write address");
        check_word(mem[exp_addr.word[7:0]], data, "VRAM word written");
        exp_addr.word = exp_addr.word + incr.word;
    end
    read_reg(regs_pkg::XM_WR_ADDR, got);
    check_word(got, exp_addr, "WR_ADDR after DATA writes");
endtask

task automatic data_read_run();
    regs_pkg::reg_word_u incr;
    regs_pkg::reg_word_u exp_addr;
    regs_pkg::reg_word_u got;
    incr.word     = random_bits(16);
    exp_addr.word = random_bits(16);
    write_reg(regs_pkg::XM_RD_INCR, incr);
    last_rd_addr.word = ~exp_addr.word;             // stale value cannot match
    write_reg(regs_pkg::XM_RD_ADDR, exp_addr);      // pre-read of the first word
    for (int i = 0; i < N_WORDS; i++) begin
        check_word(last_rd_addr, exp_addr, "VRAM read address");
        last_rd_addr.word = ~(exp_addr.word + incr.word);
        read_reg(regs_pkg::XM_DATA, got);
        check_word(got, mem[exp_addr.word[7:0]], "DATA read word");
        exp_addr.word = exp_addr.word + incr.word;
    end
    check_word(last_rd_addr, exp_addr, "VRAM read address");
    exp_addr.word = exp_addr.word + incr.word;      // last pre-read stepped once more
    read_reg(regs_pkg::XM_RD_ADDR, got);
    check_word(got, exp_addr, "RD_ADDR after DATA reads");
endtask

initial begin
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b0;
    bus_reg_num = '0;
    bus_bytesel = 1'b0;
    bus_wdata   = '0;
    vram_ack    = 1'b0;
    vram_rdata  = '0;
    for (int i = 0; i < 256; i++) begin
        mem[8'(i)].word = {8'(i) ^ 8'ha5, 8'(i * 7 + 3)};
    end
    apply_reset();
    check_reset_values();
    timer_test(int'(random_bits(8)));
    timer_test(int'(random_bits(8)));
    for (int r = 0; r < ROUNDS; r++) begin
        roundtrip_reg(regs_pkg::XM_RD_INCR, "RD_INCR");
        roundtrip_reg(regs_pkg::XM_WR_INCR, "WR_INCR");
        roundtrip_reg(regs_pkg::XM_WR_ADDR, "WR_ADDR");
    end
    check_unused_regs();
    for (int r = 0; r < ROUNDS; r++) begin
        data_write_run();
        data_read_run();
    end
    apply_reset();
    check_reset_values();
    if (uut.access.sel_checks.fail_count == 0) begin
        $display("Regression passed");
        $finish;
    end else begin
        abort_run("VRAM protocol check failed");
    end
end

initial begin
    wait (uut.access.sel_checks.fail_count != 0);
    abort_run("VRAM protocol check failed");
end

// watchdog
initial begin
    #(LIMIT_CLKS * CLK_PERIOD);
    abort_run($sformatf("Timeout: run did not finish within %0d clocks", LIMIT_CLKS));
end

endmodule

// File: vram_access.sv
`default_nettype none
`timescale 1ns/1ps

module vram_access (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        req_rd_i,      // one clock read request
    input  wire logic                        req_wr_i,      // one clock write request
    input  wire logic [regs_pkg::WORD_W-1:0] req_addr_i,
    input  wire regs_pkg::reg_word_u         req_data_i,
    input  wire logic                        vram_ack_i,    // one clock from memory
    input  wire logic [regs_pkg::WORD_W-1:0] vram_data_i,
    output      logic                        vram_sel_o,
    output      logic                        vram_wr_o,
    output      logic [regs_pkg::WORD_W-1:0] vram_addr_o,
    output      logic [regs_pkg::WORD_W-1:0] vram_data_o,
    output      logic                        done_o,        // one clock when access ends
    output      logic                        done_wr_o,     // kind of the finished access
    output      regs_pkg::reg_word_u         rd_word_o      // valid with done of a read
);

logic ack_seen;
logic start;

assign ack_seen = vram_sel_o & vram_ack_i;
assign start    = ~vram_sel_o & (req_rd_i | req_wr_i);   // request while busy is lost

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o <= 1'b0;
        vram_wr_o  <= 1'b0;
        done_o     <= 1'b0;
        done_wr_o  <= 1'b0;
    end else begin
        done_o <= 1'b0;
        if (ack_seen) begin
            vram_sel_o <= 1'b0;                 // falls the clock after ack
            vram_wr_o  <= 1'b0;
            done_o     <= 1'b1;
            done_wr_o  <= vram_wr_o;
        end else if (start) begin
            vram_sel_o <= 1'b1;
            vram_wr_o  <= req_wr_i;
        end
    end
end

// address and data stay put from start until ack
always_ff @(posedge clk) begin
    if (start) begin
        vram_addr_o <= req_addr_i;
        vram_data_o <= req_data_i.word;
    end
end

always_ff @(posedge clk) begin
    if (ack_seen && !vram_wr_o) begin
        rd_word_o.word <= vram_data_i;
    end
end

endmodule

`default_nettype wire

// File: vram_regs.sv
`default_nettype none
`timescale 1ns/1ps

module vram_regs #(
    parameter int TIMER_DIV = bus_pkg::TIMER_DIV_DEFAULT   // clocks per timer tick
) (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           write_strobe_i,
    input  wire logic                           read_strobe_i,
    input  wire logic [regs_pkg::REG_NUM_W-1:0] reg_num_i,
    input  wire logic                           bytesel_i,
    input  wire logic [regs_pkg::BYTE_W-1:0]    bytedata_i,
    input  wire logic                           done_i,         // VRAM access finished
    input  wire logic                           done_wr_i,      // finished access was a write
    input  wire regs_pkg::reg_word_u            rd_word_i,      // read result, valid with done
    output      logic                           req_rd_o,
    output      logic                           req_wr_o,
    output      logic [regs_pkg::WORD_W-1:0]    req_addr_o,
    output      regs_pkg::reg_word_u            req_data_o,
    output      logic [regs_pkg::BYTE_W-1:0]    bus_data_o      // readback byte
);

localparam int FRAC_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

regs_pkg::reg_word_u            rd_incr;
regs_pkg::reg_word_u            rd_addr;
regs_pkg::reg_word_u            wr_incr;
regs_pkg::reg_word_u            wr_addr;
regs_pkg::reg_word_u            rd_data;        // last word read from VRAM
regs_pkg::reg_word_u            rb_word;        // word selected for readback
logic [regs_pkg::BYTE_W-1:0]    data_even;      // even byte of a DATA write
logic [regs_pkg::WORD_W-1:0]    timer;
logic [FRAC_W-1:0]              timer_frac;     // clocks within one tick

logic                           wr_even;
logic                           wr_odd;
logic                           rd_odd;

assign wr_even = write_strobe_i & ~bytesel_i;
assign wr_odd  = write_strobe_i & bytesel_i;
assign rd_odd  = read_strobe_i & bytesel_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        rd_incr  <= '0;
        rd_addr  <= '0;
        wr_incr  <= '0;
        wr_addr  <= '0;
        rd_data  <= '0;
        req_rd_o <= 1'b0;
        req_wr_o <= 1'b0;
    end else begin
        req_rd_o <= 1'b0;
        req_wr_o <= 1'b0;

        // finished access steps its address
        if (done_i) begin
            if (done_wr_i) begin
                wr_addr.word <= wr_addr.word + wr_incr.word;
            end else begin
                rd_data      <= rd_word_i;
                rd_addr.word <= rd_addr.word + rd_incr.word;
            end
        end

        if (wr_even) begin
            case (reg_num_i)
                regs_pkg::XM_RD_INCR: rd_incr.bytes.hi <= bytedata_i;
                regs_pkg::XM_RD_ADDR: rd_addr.bytes.hi <= bytedata_i;
                regs_pkg::XM_WR_INCR: wr_incr.bytes.hi <= bytedata_i;
                regs_pkg::XM_WR_ADDR: wr_addr.bytes.hi <= bytedata_i;
                regs_pkg::XM_DATA:    data_even        <= bytedata_i;  // held for odd byte
                default: ;
            endcase
        end

        // odd byte completes the word
        if (wr_odd) begin
            case (reg_num_i)
                regs_pkg::XM_RD_INCR: rd_incr.bytes.lo <= bytedata_i;
                regs_pkg::XM_RD_ADDR: begin
                    rd_addr.bytes.lo <= bytedata_i;
                    req_addr_o       <= {rd_addr.bytes.hi, bytedata_i};   // pre-read
                    req_rd_o         <= 1'b1;
                end
                regs_pkg::XM_WR_INCR: wr_incr.bytes.lo <= bytedata_i;
                regs_pkg::XM_WR_ADDR: wr_addr.bytes.lo <= bytedata_i;
                regs_pkg::XM_DATA: begin
                    req_addr_o          <= wr_addr.word;
                    req_data_o.bytes.hi <= data_even;
                    req_data_o.bytes.lo <= bytedata_i;
                    req_wr_o            <= 1'b1;
                end
                default: ;
            endcase
        end

        // reading the odd DATA byte fetches the next word
        if (rd_odd && reg_num_i == regs_pkg::XM_DATA) begin
            req_addr_o <= rd_addr.word;
            req_rd_o   <= 1'b1;
        end
    end
end

// free running tick counter
always_ff @(posedge clk) begin
    if (reset_i) begin
        timer      <= '0;
        timer_frac <= '0;
    end else if (timer_frac == FRAC_W'(TIMER_DIV - 1)) begin
        timer_frac <= '0;
        timer      <= timer + 1'b1;
    end else begin
        timer_frac <= timer_frac + 1'b1;
    end
end

always_comb begin
    case (reg_num_i)
        regs_pkg::XM_RD_INCR: rb_word = rd_incr;
        regs_pkg::XM_RD_ADDR: rb_word = rd_addr;
        regs_pkg::XM_WR_INCR: rb_word = wr_incr;
        regs_pkg::XM_WR_ADDR: rb_word = wr_addr;
        regs_pkg::XM_DATA:    rb_word = rd_data;
        regs_pkg::XM_TIMER:   rb_word.word = timer;
        default:              rb_word = '0;     // unused numbers
    endcase
    bus_data_o = bytesel_i ? rb_word.bytes.lo : rb_word.bytes.hi;
end

endmodule

`default_nettype wire

// File: xm_regs_asserts.sv
`timescale 1ns/1ps

module xm_regs_asserts (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        sel_i,
    input logic                        wr_i,
    input logic [regs_pkg::WORD_W-1:0] addr_i,
    input logic [regs_pkg::WORD_W-1:0] wdata_i,
    input logic                        ack_i,
    input logic                        done_i
);

int unsigned fail_count = 0;    // failed checks so far

sel_low_after_reset: assert property (@(posedge clk) reset_i |=> !sel_i)
    else begin
        fail_count++;
        $error("VRAM select high after reset");
    end

// request fields held until the memory answers
fields_stable: assert property (@(posedge clk) disable iff (reset_i)
    sel_i && !ack_i |=> sel_i && $stable(addr_i) && $stable(wdata_i) && $stable(wr_i))
    else begin
        fail_count++;
        $error("VRAM request changed before ack");
    end

ack_inside_sel: assert property (@(posedge clk) disable iff (reset_i) ack_i |-> sel_i)
    else begin
        fail_count++;
        $error("VRAM ack without select");
    end

sel_falls_after_ack: assert property (@(posedge clk) disable iff (reset_i)
    sel_i && ack_i |=> !sel_i && done_i)
    else begin
        fail_count++;
        $error("VRAM select or done wrong after ack");
    end

endmodule

bind vram_access xm_regs_asserts sel_checks (
    .clk     (clk),
    .reset_i (reset_i),
    .sel_i   (vram_sel_o),
    .wr_i    (vram_wr_o),
    .addr_i  (vram_addr_o),
    .wdata_i (vram_data_o),
    .ack_i   (vram_ack_i),
    .done_i  (done_o)
);

// File: xm_regs_top.sv
`default_nettype none
`timescale 1ns/1ps

module xm_regs_top #(
    parameter int TIMER_DIV = bus_pkg::TIMER_DIV_DEFAULT
) (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           bus_cs_n_i,
    input  wire logic                           bus_rd_nwr_i,
    input  wire logic [regs_pkg::REG_NUM_W-1:0] bus_reg_num_i,
    input  wire logic                           bus_bytesel_i,
    input  wire logic [regs_pkg::BYTE_W-1:0]    bus_data_i,
    output      logic [regs_pkg::BYTE_W-1:0]    bus_data_o,
    output      logic                           vram_sel_o,
    output      logic                           vram_wr_o,
    output      logic [regs_pkg::WORD_W-1:0]    vram_addr_o,
    output      logic [regs_pkg::WORD_W-1:0]    vram_data_o,
    input  wire logic                           vram_ack_i,
    input  wire logic [regs_pkg::WORD_W-1:0]    vram_data_i
);

logic                           write_strobe;
logic                           read_strobe;
logic [regs_pkg::REG_NUM_W-1:0] reg_num;
logic                           bytesel;
logic [regs_pkg::BYTE_W-1:0]    bytedata;
logic                           req_rd;
logic                           req_wr;
logic [regs_pkg::WORD_W-1:0]    req_addr;
regs_pkg::reg_word_u            req_data;
logic                           done;
logic                           done_wr;
regs_pkg::reg_word_u            rd_word;

bus_sync bus (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .write_strobe_o (write_strobe),
    .read_strobe_o  (read_strobe),
    .reg_num_o      (reg_num),
    .bytesel_o      (bytesel),
    .bytedata_o     (bytedata)
);

vram_regs #(
    .TIMER_DIV (TIMER_DIV)
) regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .write_strobe_i (write_strobe),
    .read_strobe_i  (read_strobe),
    .reg_num_i      (reg_num),
    .bytesel_i      (bytesel),
    .bytedata_i     (bytedata),
    .done_i         (done),
    .done_wr_i      (done_wr),
    .rd_word_i      (rd_word),
    .req_rd_o       (req_rd),
    .req_wr_o       (req_wr),
    .req_addr_o     (req_addr),
    .req_data_o     (req_data),
    .bus_data_o     (bus_data_o)
);

vram_access access (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_rd_i    (req_rd),
    .req_wr_i    (req_wr),
    .req_addr_i  (req_addr),
    .req_data_i  (req_data),
    .vram_ack_i  (vram_ack_i),
    .vram_data_i (vram_data_i),
    .vram_sel_o  (vram_sel_o),
    .vram_wr_o   (vram_wr_o),
    .vram_addr_o (vram_addr_o),
    .vram_data_o (vram_data_o),
    .done_o      (done),
    .done_wr_o   (done_wr),
    .rd_word_o   (rd_word)
);

endmodule

`default_nettype wire
